//--- design/axi_burst_config.svh
`ifndef AXI_BURST_CONFIG_SVH
`define AXI_BURST_CONFIG_SVH

// Bus widths
`define AXI_ADDR_W 16
`define AXI_DATA_W 32

// Burst shape, BURST_LEN is 2**BURST_W
`define BURST_W 3
`define BURST_LEN 8

// Buffer holds 2**BUFFER_W beats
`define BUFFER_W 4

// Bursts may not cross this page
`define BOUNDARY_BYTES 4096

`endif

//--- design/axi_bus_pkg.sv
`include "axi_burst_config.svh"

package axi_bus_pkg;

   // Write address channel
   // Size is fixed at 4 bytes and burst type at INCR, so only
   // the start address and beat count travel here
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [7:0]             len;
   } aw_chan_t;

   // Write data channel
   // Strobes are always all ones
   typedef struct packed {
      logic [`AXI_DATA_W-1:0] data;
      logic                   last;
   } w_chan_t;

   // Write response channel
   typedef struct packed {
      logic [1:0] resp;
   } b_chan_t;

endpackage

//--- design/axis_axi_writer_top.sv
`include "axi_burst_config.svh"

module axis_axi_writer_top import axi_bus_pkg::*, stream_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  cfg_req_t cfg_i,
   input  logic     cfg_valid_i,
   output logic     cfg_ready_o,

   input  beat_t    s_beat_i,
   input  logic     s_valid_i,
   output logic     s_ready_o,

   output aw_chan_t aw_o,
   output logic     aw_valid_o,
   input  logic     aw_ready_i,

   output w_chan_t  w_o,
   output logic     w_valid_o,
   input  logic     w_ready_i,

   input  b_chan_t  b_i,
   input  logic     b_valid_i,
   output logic     b_ready_o
);

   beat_t                  push_beat;
   logic                   push_valid;
   logic                   push_ready;
   beat_t                  head_beat;
   logic                   not_empty;
   logic                   pop;
   logic [`BUFFER_W:0]     level;
   logic                   in_flight;
   logic [`AXI_ADDR_W-1:0] start_addr;
   logic                   load_addr;
   logic                   writer_idle;

   stream_ingest ingest_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .cfg_i           (cfg_i),
      .cfg_valid_i     (cfg_valid_i),
      .cfg_ready_o     (cfg_ready_o),
      .s_beat_i        (s_beat_i),
      .s_valid_i       (s_valid_i),
      .s_ready_o       (s_ready_o),
      .push_beat_o     (push_beat),
      .push_valid_o    (push_valid),
      .push_ready_i    (push_ready),
      .buf_not_empty_i (not_empty),
      .writer_idle_i   (writer_idle),
      .start_addr_o    (start_addr),
      .load_addr_o     (load_addr),
      .in_flight_o     (in_flight)
   );

   beat_fifo fifo_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_beat_i  (push_beat),
      .push_valid_i (push_valid),
      .push_ready_o (push_ready),
      .head_beat_o  (head_beat),
      .not_empty_o  (not_empty),
      .pop_i        (pop),
      .level_o      (level)
   );

   burst_writer writer_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .level_i       (level),
      .head_beat_i   (head_beat),
      .pop_o         (pop),
      .in_flight_i   (in_flight),
      .start_addr_i  (start_addr),
      .load_addr_i   (load_addr),
      .writer_idle_o (writer_idle),
      .aw_o          (aw_o),
      .aw_valid_o    (aw_valid_o),
      .aw_ready_i    (aw_ready_i),
      .w_o           (w_o),
      .w_valid_o     (w_valid_o),
      .w_ready_i     (w_ready_i),
      .b_i           (b_i),
      .b_valid_i     (b_valid_i),
      .b_ready_o     (b_ready_o)
   );

endmodule

//--- design/beat_fifo.sv
`include "axi_burst_config.svh"

module beat_fifo import stream_pkg::*; (
   input  logic                 clk_i,
   input  logic                 rst_n_i,

   input  beat_t                push_beat_i,
   input  logic                 push_valid_i,
   output logic                 push_ready_o,

   output beat_t                head_beat_o,
   output logic                 not_empty_o,
   input  logic                 pop_i,

   output logic [`BUFFER_W:0]   level_o
);

   localparam int DEPTH = 2 ** `BUFFER_W;

   beat_t                 mem [DEPTH];
   logic [`BUFFER_W-1:0]  wr_ptr;
   logic [`BUFFER_W-1:0]  rd_ptr;
   logic [`BUFFER_W:0]    level_q;
   logic                  do_push;
   logic                  do_pop;

   assign push_ready_o = (level_q != DEPTH[`BUFFER_W:0]);
   assign not_empty_o  = (level_q != '0);
   assign level_o      = level_q;

   assign do_push = push_valid_i && push_ready_o;
   assign do_pop  = pop_i && not_empty_o;

   // Head read straight from the array, no output register
   assign head_beat_o = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= push_beat_i;
      end
   end

   // Pointers wrap naturally at DEPTH
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else begin
         case ({do_push, do_pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

endmodule

//--- design/burst_writer.sv
`include "axi_burst_config.svh"

module burst_writer import axi_bus_pkg::*, stream_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   input  logic [`BUFFER_W:0]     level_i,
   input  beat_t                  head_beat_i,
   output logic                   pop_o,
   input  logic                   in_flight_i,
   input  logic [`AXI_ADDR_W-1:0] start_addr_i,
   input  logic                   load_addr_i,
   output logic                   writer_idle_o,

   output aw_chan_t               aw_o,
   output logic                   aw_valid_o,
   input  logic                   aw_ready_i,
   output w_chan_t                w_o,
   output logic                   w_valid_o,
   input  logic                   w_ready_i,
   input  b_chan_t                b_i,
   input  logic                   b_valid_i,
   output logic                   b_ready_o
);

   localparam int PAGE_W = $clog2(`BOUNDARY_BYTES);

   typedef enum logic [1:0] {
      IDLE,
      ADDR,
      DATA,
      RESP
   } state_t;

   state_t                 state_q;
   state_t                 state_d;
   logic [`AXI_ADDR_W-1:0] addr_q;
   logic [`BURST_W-1:0]    len_q;
   logic [`BURST_W-1:0]    beat_cnt;

   logic                   full_burst;
   logic                   flush_burst;
   logic                   start;
   logic [`BURST_W:0]      want_beats;
   logic [PAGE_W:0]        room_bytes;
   logic [PAGE_W:0]        room_beats;
   logic [`BURST_W:0]      burst_beats;
   logic [`BURST_W:0]      beats_q;
   logic                   w_xfer;
   logic                   last_beat;

   // Burst start conditions
   assign full_burst  = (level_i >= `BURST_LEN);
   assign flush_burst = (level_i != '0) && !in_flight_i;
   // Skip the cycle in which a new start address is being loaded
   assign start       = (state_q == IDLE) && (full_burst || flush_burst) && !load_addr_i;

   // A flush only happens below BURST_LEN, so the low bits hold the whole level
   assign want_beats = full_burst ? (`BURST_W+1)'(`BURST_LEN) : level_i[`BURST_W:0];

   // Beats left in the current 4 KB page
   assign room_bytes = (PAGE_W+1)'(`BOUNDARY_BYTES) - {1'b0, addr_q[PAGE_W-1:0]};
   assign room_beats = room_bytes >> 2;

   always_comb begin
      burst_beats = want_beats;
      if (room_beats < {{(PAGE_W-`BURST_W){1'b0}}, want_beats}) begin
         burst_beats = room_beats[`BURST_W:0];
      end
   end

   assign beats_q   = {1'b0, len_q} + 1'b1;
   assign w_xfer    = w_valid_o && w_ready_i;
   assign last_beat = (beat_cnt == len_q);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (start) begin
               state_d = ADDR;
            end
         end
         ADDR: begin
            if (aw_ready_i) begin
               state_d = DATA;
            end
         end
         DATA: begin
            if (w_xfer && last_beat) begin
               state_d = RESP;
            end
         end
         RESP: begin
            if (b_valid_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= IDLE;
         addr_q   <= '0;
         len_q    <= '0;
         beat_cnt <= '0;
      end else begin
         state_q <= state_d;
         if (start) begin
            // Size is fixed for the whole burst once chosen
            len_q    <= burst_beats[`BURST_W-1:0] - 1'b1;
            beat_cnt <= '0;
         end else if (w_xfer) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
         if (state_q == IDLE && load_addr_i) begin
            addr_q <= start_addr_i;
         end else if (state_q == RESP && b_valid_i) begin
            addr_q <= addr_q + {{(`AXI_ADDR_W-`BURST_W-3){1'b0}}, beats_q, 2'b00};
         end
      end
   end

   assign aw_o.addr  = addr_q;
   assign aw_o.len   = {{(8-`BURST_W){1'b0}}, len_q};
   assign aw_valid_o = (state_q == ADDR);

   // Buffer holds at least the whole burst, so data is always ready
   assign w_o.data  = head_beat_i.data;
   assign w_o.last  = last_beat;
   assign w_valid_o = (state_q == DATA);
   assign pop_o     = w_xfer;

   // Response code is not checked, b_i only closes the burst
   assign b_ready_o     = 1'b1;
   assign writer_idle_o = (state_q == IDLE);

endmodule

//--- design/stream_ingest.sv
`include "axi_burst_config.svh"

module stream_ingest import stream_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   input  cfg_req_t               cfg_i,
   input  logic                   cfg_valid_i,
   output logic                   cfg_ready_o,

   input  beat_t                  s_beat_i,
   input  logic                   s_valid_i,
   output logic                   s_ready_o,

   output beat_t                  push_beat_o,
   output logic                   push_valid_o,
   input  logic                   push_ready_i,
   input  logic                   buf_not_empty_i,

   input  logic                   writer_idle_i,
   output logic [`AXI_ADDR_W-1:0] start_addr_o,
   output logic                   load_addr_o,
   output logic                   in_flight_o
);

   logic                   out_valid;
   logic                   skid_valid;
   beat_t                  out_beat;
   beat_t                  skid_beat;
   logic [`AXI_ADDR_W-1:0] start_addr_q;
   logic                   load_q;
   logic                   accept;
   logic                   out_free;
   logic                   cfg_take;

   assign accept   = s_valid_i && s_ready_o;
   // Output slot empties this cycle, or is already empty
   assign out_free = !out_valid || push_ready_i;
   assign cfg_take = cfg_valid_i && cfg_ready_o;

   // Second entry catches the beat that arrives while the buffer stalls
   assign s_ready_o = !skid_valid;

   // New start address only once everything queued has been written
   assign cfg_ready_o = writer_idle_i && !out_valid && !skid_valid && !buf_not_empty_i;

   // Lets the writer tell a short pause from the end of a stream
   assign in_flight_o = out_valid || skid_valid || s_valid_i;

   assign push_beat_o  = out_beat;
   assign push_valid_o = out_valid;
   assign start_addr_o = start_addr_q;
   assign load_addr_o  = load_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
         load_q     <= 1'b0;
      end else begin
         load_q <= cfg_take;
         if (out_free) begin
            out_valid  <= skid_valid || accept;
            skid_valid <= 1'b0;
         end else if (accept) begin
            skid_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_free) begin
         if (skid_valid) begin
            out_beat <= skid_beat;
         end else if (accept) begin
            out_beat <= s_beat_i;
         end
      end else if (accept) begin
         skid_beat <= s_beat_i;
      end
      if (cfg_take) begin
         start_addr_q <= {cfg_i.addr[`AXI_ADDR_W-1:2], 2'b00};
      end
   end

endmodule

//--- design/stream_pkg.sv
`include "axi_burst_config.svh"

package stream_pkg;

   // One stream word, written as one AXI beat
   typedef struct packed {
      logic [`AXI_DATA_W-1:0] data;
   } beat_t;

   // Start address for the next run of beats
   // Bits 1:0 are dropped, writes are word aligned
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
   } cfg_req_t;

endpackage

//--- list.f
+incdir+design
design/axi_bus_pkg.sv
design/stream_pkg.sv
design/stream_ingest.sv
design/beat_fifo.sv
design/burst_writer.sv
design/axis_axi_writer_top.sv
tb/axi_mem_slave.sv
tb/tb_axis_axi_writer.sv

//--- tb/axi_mem_slave.sv
`include "axi_burst_config.svh"

module axi_mem_slave import axi_bus_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     stall_en_i,

   input  aw_chan_t aw_i,
   input  logic     aw_valid_i,
   output logic     aw_ready_o,

   input  w_chan_t  w_i,
   input  logic     w_valid_i,
   output logic     w_ready_o,

   output b_chan_t  b_o,
   output logic     b_valid_o,
   input  logic     b_ready_i
);

   localparam int MEM_BYTES = 2 ** `AXI_ADDR_W;

   // Byte-addressed backing store
   logic [7:0]             mem [MEM_BYTES];
   // One entry per accepted AW, one per W beat marked last
   aw_chan_t               aw_log [$];
   int unsigned            last_log [$];
   logic [`AXI_ADDR_W-1:0] wr_addr;
   int unsigned            beat_cnt;
   logic                   b_pending;

   // Always OKAY
   assign b_o = '0;

   // Ready and handshake decided together on the falling edge,
   // valid and payload from the DUT hold until the next rising edge
   initial begin
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      b_valid_o  = 1'b0;
      b_pending  = 1'b0;
      wr_addr    = '0;
      beat_cnt   = 0;
      for (int a = 0; a < MEM_BYTES; a++) begin
         mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
      end
      forever begin
         @(negedge clk_i);
         if (!rst_n_i) begin
            aw_ready_o = 1'b0;
            w_ready_o  = 1'b0;
            b_valid_o  = 1'b0;
            b_pending  = 1'b0;
         end else begin
            // Response slot
            if (b_valid_o && b_ready_i) begin
               b_valid_o = 1'b0;
            end
            if (b_pending) begin
               b_valid_o = 1'b1;
               b_pending = 1'b0;
            end
            aw_ready_o = stall_en_i ? (($urandom % 4) != 0) : 1'b1;
            if (aw_valid_i && aw_ready_o) begin
               aw_log.push_back(aw_i);
               wr_addr  = aw_i.addr;
               beat_cnt = 0;
            end
            w_ready_o = stall_en_i ? (($urandom % 3) != 0) : 1'b1;
            if (w_valid_i && w_ready_o) begin
               // Little endian, all strobes set
               mem[wr_addr]         = w_i.data[7:0];
               mem[wr_addr + 16'd1] = w_i.data[15:8];
               mem[wr_addr + 16'd2] = w_i.data[23:16];
               mem[wr_addr + 16'd3] = w_i.data[31:24];
               wr_addr  = wr_addr + 16'd4;
               beat_cnt = beat_cnt + 1;
               if (w_i.last) begin
                  last_log.push_back(beat_cnt);
                  b_pending = 1'b1;
               end
            end
         end
      end
   end

endmodule

//--- tb/tb_axis_axi_writer.sv
`include "axi_burst_config.svh"

module tb_axis_axi_writer import axi_bus_pkg::*, stream_pkg::*; ();

   localparam logic [31:0] SEED        = 32'h3e054798;
   // 40 + 11 + 20 + 60 + 11 + 9 beats over all cases
   localparam int          TOTAL_BEATS = 151;
   localparam int          CYCLE_LIMIT = 40 * TOTAL_BEATS + 2000;

   typedef aw_chan_t aw_list_t [$];

   logic     clk_i;
   logic     rst_n_i;
   cfg_req_t cfg_i;
   logic     cfg_valid_i;
   logic     cfg_ready_o;
   beat_t    s_beat_i;
   logic     s_valid_i;
   logic     s_ready_o;
   aw_chan_t aw_o;
   logic     aw_valid_o;
   logic     aw_ready_i;
   w_chan_t  w_o;
   logic     w_valid_o;
   logic     w_ready_i;
   b_chan_t  b_i;
   logic     b_valid_i;
   logic     b_ready_o;
   logic     stall_en;

   beat_t       sent [$];
   aw_list_t    exp_q;
   logic        exact_mode;
   int unsigned beats_done;
   int unsigned cycles;

   axis_axi_writer_top dut_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_i       (cfg_i),
      .cfg_valid_i (cfg_valid_i),
      .cfg_ready_o (cfg_ready_o),
      .s_beat_i    (s_beat_i),
      .s_valid_i   (s_valid_i),
      .s_ready_o   (s_ready_o),
      .aw_o        (aw_o),
      .aw_valid_o  (aw_valid_o),
      .aw_ready_i  (aw_ready_i),
      .w_o         (w_o),
      .w_valid_o   (w_valid_o),
      .w_ready_i   (w_ready_i),
      .b_i         (b_i),
      .b_valid_i   (b_valid_i),
      .b_ready_o   (b_ready_o)
   );

   axi_mem_slave slave_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .stall_en_i (stall_en),
      .aw_i       (aw_o),
      .aw_valid_i (aw_valid_o),
      .aw_ready_o (aw_ready_i),
      .w_i        (w_o),
      .w_valid_i  (w_valid_o),
      .w_ready_o  (w_ready_i),
      .b_o        (b_i),
      .b_valid_o  (b_valid_i),
      .b_ready_i  (b_ready_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
         abort_run("single-bit output has the wrong level");
      end
   endtask

   task automatic check_beat(input string name, input beat_t got, input beat_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got.data, exp.data);
         abort_run("stored word differs from the beat sent");
      end
   endtask

   task automatic check_aw(input string name, input aw_chan_t got, input aw_chan_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got addr 0x%04h len 0x%02h expected addr 0x%04h len 0x%02h",
                  name, got.addr, got.len, exp.addr, exp.len);
         abort_run("burst differs from the expected burst");
      end
   endtask

   // Bursts of at most BURST_LEN beats, cut at each 4 KB page end
   function automatic aw_list_t expected_bursts(input logic [15:0] start,
                                                input int unsigned count);
      aw_list_t    list;
      aw_chan_t    burst;
      int unsigned addr;
      int unsigned left;
      int unsigned room;
      int unsigned n;
      addr = int'(start) & 32'hfffc;
      left = count;
      while (left > 0) begin
         room = (`BOUNDARY_BYTES - (addr % `BOUNDARY_BYTES)) / 4;
         n = (left < `BURST_LEN) ? left : `BURST_LEN;
         if (room < n) begin
            n = room;
         end
         burst.addr = 16'(addr);
         burst.len  = 8'(n - 1);
         list.push_back(burst);
         addr = (addr + 4 * n) % 65536;
         left = left - n;
      end
      return list;
   endfunction

   // Compares each burst once its last beat has been written
   always @(negedge clk_i) begin : burst_check
      aw_chan_t    got;
      aw_chan_t    seen;
      int unsigned beats;
      if (slave_i.last_log.size() > 0) begin
         got   = slave_i.aw_log.pop_front();
         beats = slave_i.last_log.pop_front();
         seen     = got;
         seen.len = 8'(beats - 1);
         check_aw("w_o.last", seen, got);
         if (int'(got.len) + 1 > `BURST_LEN) begin
            abort_run($sformatf("burst at 0x%04h is longer than the maximum", got.addr));
         end
         if ((int'(got.addr) % `BOUNDARY_BYTES) + 4 * (int'(got.len) + 1) >
             `BOUNDARY_BYTES) begin
            abort_run($sformatf("burst at 0x%04h crosses a 4 KB boundary", got.addr));
         end
         if (exact_mode) begin
            if (exp_q.size() == 0) begin
               abort_run("a burst was written when none was expected");
            end
            check_aw("aw_o", got, exp_q.pop_front());
         end
         beats_done = beats_done + int'(got.len) + 1;
      end
   end

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         abort_run($sformatf("Timeout after %0d cycles without finishing", cycles));
      end
   end

   // Handshake outputs come from registers, so the level seen here holds to the edge
   task automatic load_config(input logic [15:0] addr);
      logic took;
      cfg_i.addr  = addr;
      cfg_valid_i = 1'b1;
      took        = 1'b0;
      while (!took) begin
         took = cfg_ready_o;
         @(negedge clk_i);
      end
      cfg_valid_i = 1'b0;
   endtask

   task automatic push_beat(input beat_t beat);
      logic took;
      s_beat_i  = beat;
      s_valid_i = 1'b1;
      took      = 1'b0;
      while (!took) begin
         took = s_ready_o;
         @(negedge clk_i);
      end
   endtask

   task automatic send_beats(input int unsigned n, input logic gaps);
      beat_t       beat;
      int unsigned idle;
      for (int i = 0; i < n; i++) begin
         beat.data = $urandom;
         sent.push_back(beat);
         push_beat(beat);
         if (gaps) begin
            idle = $urandom % 4;
            if (idle != 0) begin
               s_valid_i = 1'b0;
               repeat (idle) @(negedge clk_i);
            end
         end
      end
      s_valid_i = 1'b0;
   endtask

   task automatic wait_drained(input int unsigned target);
      while (beats_done < target || !cfg_ready_o) begin
         // No new start address while beats remain or a burst is open
         if (beats_done < target || aw_valid_o || w_valid_o) begin
            check_flag("cfg_ready_o", cfg_ready_o, 1'b0);
         end
         check_flag("b_ready_o", b_ready_o, 1'b1);
         @(negedge clk_i);
      end
   endtask

   task automatic check_memory(input logic [15:0] start);
      logic [15:0] addr;
      beat_t       got;
      for (int i = 0; i < sent.size(); i++) begin
         addr     = {start[15:2], 2'b00} + 16'(4 * i);
         got.data = {slave_i.mem[addr + 16'd3], slave_i.mem[addr + 16'd2],
                     slave_i.mem[addr + 16'd1], slave_i.mem[addr]};
         check_beat($sformatf("mem[0x%04h]", addr), got, sent[i]);
      end
   endtask

   task automatic run_case(input logic [15:0] start, input int unsigned n,
                           input logic gaps, input logic exact);
      load_config(start);
      exact_mode = exact;
      exp_q      = expected_bursts(start, n);
      beats_done = 0;
      sent.delete();
      send_beats(n, gaps);
      // Last beat still sits in the ingest slice or the FIFO
      check_flag("cfg_ready_o", cfg_ready_o, 1'b0);
      wait_drained(n);
      if (exact && exp_q.size() != 0) begin
         abort_run($sformatf("%0d expected bursts were never written", exp_q.size()));
      end
      check_memory(start);
   endtask

   initial begin
      void'($urandom(SEED));
      rst_n_i     = 1'b0;
      cfg_i       = '0;
      cfg_valid_i = 1'b0;
      s_beat_i    = '0;
      s_valid_i   = 1'b0;
      stall_en    = 1'b0;
      exact_mode  = 1'b0;
      beats_done  = 0;
      cycles      = 0;
      repeat (8) @(negedge clk_i);
      rst_n_i = 1'b1;
      @(negedge clk_i);

      check_flag("aw_valid_o", aw_valid_o, 1'b0);
      check_flag("w_valid_o", w_valid_o, 1'b0);
      check_flag("cfg_ready_o", cfg_ready_o, 1'b1);
      check_flag("s_ready_o", s_ready_o, 1'b1);
      check_flag("b_ready_o", b_ready_o, 1'b1);

      run_case(16'h0100, 40, 1'b0, 1'b1);
      run_case(16'h0400, 11, 1'b0, 1'b1);
      // Page end after 4 beats
      run_case(16'h0ff0, 20, 1'b0, 1'b1);
      stall_en = 1'b1;
      run_case(16'h2fc8, 60, 1'b1, 1'b0);
      stall_en = 1'b0;
      // New start address once the first run has drained
      run_case(16'h5000, 11, 1'b0, 1'b1);
      run_case(16'h6004, 9, 1'b0, 1'b1);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
